/* filelist.f */
+incdir+.
sam_pkg.sv
sam_bus_decoder.sv
ram_dual_port.sv
video_fetch.sv
keyboard_matrix.sv
rom.sv
samcoupe_core.sv
tb_samcoupe.sv

/* keyboard_matrix.sv */
`timescale 1ns/10ps
`default_nettype none

module keyboard_matrix (
    input  wire                     clk24,
    input  wire                     reset,
    input  wire                     key_valid,
    input  wire sam_pkg::key_event_t key,
    input  wire logic [7:0]         kb_rows,
    output logic [4:0]              kb_cols
);
    import sam_pkg::*;

    // One bit per key with 1 meaning held
    logic [7:0][4:0] key_down;

    // Columns 5 to 7 do not exist
    always_ff @(posedge clk24) begin
        if (reset) begin
            key_down <= '0;
        end else if (key_valid && (key.col < 3'd5)) begin
            key_down[key.row][key.col] <= key.make;
        end
    end

    // Held keys pull their column low in any selected row
    always_comb begin
        kb_cols = 5'b11111;
        for (int r = 0; r < 8; r++) begin
            if (!kb_rows[r]) begin
                kb_cols = kb_cols & ~key_down[r];
            end
        end
    end

endmodule

`default_nettype wire

/* ram_dual_port.sv */
`timescale 1ns/10ps
`default_nettype none

module ram_dual_port (
    input  wire                    clk24,
    input  wire                    reset,
    input  wire                    vid_req,
    input  wire sam_pkg::sram_addr_t vid_addr,
    input  wire sam_pkg::ram_req_t cpu_ram_req,
    input  wire sam_pkg::byte_t    sram_din,
    output logic                   whichturn,
    output sam_pkg::byte_t         vid_rdata,
    output logic                   vid_valid,
    output logic                   cpu_ram_done,
    output sam_pkg::byte_t         cpu_ram_rdata,
    output sam_pkg::sram_addr_t    sram_addr,
    output sam_pkg::byte_t         sram_dout,
    output logic                   sram_we
);
    import sam_pkg::*;

    arb_state_t state;
    logic       cpu_pending;

    assign cpu_pending = cpu_ram_req.rd | cpu_ram_req.wr;

    // Every slot other than slot_cpu belongs to video
    assign whichturn = (state != slot_cpu);
    // Done is a video slot right after a served CPU slot
    assign cpu_ram_done = (state == slot_cpu_done);

    ////////////////////////////////////////////////////////////
    // Slot machine
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk24) begin
        if (reset) begin
            state <= slot_video;
        end else begin
            case (state)
                slot_cpu: state <= cpu_pending ? slot_cpu_done : slot_video;
                default:  state <= slot_cpu;
            endcase
        end
    end

    // SRAM pins follow the owner of the slot
    assign sram_addr = whichturn ? vid_addr : cpu_ram_req.addr;
    assign sram_dout = cpu_ram_req.wdata;
    assign sram_we   = (state == slot_cpu) && cpu_ram_req.wr;

    // Video return valid in the following cycle
    always_ff @(posedge clk24) begin
        if (reset) begin
            vid_valid <= 1'b0;
        end else begin
            vid_valid <= whichturn && vid_req;
        end
    end

    // Capture async read data at slot end
    always_ff @(posedge clk24) begin
        if (whichturn) begin
            vid_rdata <= sram_din;
        end else if (cpu_ram_req.rd) begin
            cpu_ram_rdata <= sram_din;
        end
    end

endmodule

`default_nettype wire

/* rom.hex */
// ROM image for $readmemh with one hex byte per line
// @0000 starts ROM0 and @4000 starts ROM1 which the CPU sees at C000
@0000
F3
C3
CB
11
ED
56
@4000
A5
5A
3C
96
0F
E1

/* rom.sv */
`timescale 1ns/10ps
`default_nettype none
`include "sam_consts.svh"

module rom (
    input  wire              clk24,
    input  wire              rom_cs,
    input  wire logic [14:0] rom_addr,
    output sam_pkg::byte_t   rom_data
);
    import sam_pkg::*;

    // ROM0 in the low half and ROM1 in the high half
    byte_t mem [0:`SAM_ROM_WORDS-1];

    initial begin
        $readmemh("rom.hex", mem);
    end

    // Registered read
    always_ff @(posedge clk24) begin
        if (rom_cs) begin
            rom_data <= mem[rom_addr];
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
    -f filelist.f --top-module tb_samcoupe -o sim_samcoupe

out=$(./obj_dir/sim_samcoupe)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

/* sam_bus_decoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "sam_consts.svh"

module sam_bus_decoder (
    input  wire                  clk24,
    input  wire                  reset,
    input  wire sam_pkg::cpu_bus_t cpu,
    input  wire logic [4:0]      kb_cols,
    input  wire                  cpu_ram_done,
    input  wire sam_pkg::byte_t  cpu_ram_rdata,
    input  wire sam_pkg::byte_t  rom_data,
    output sam_pkg::byte_t       cpu_din,
    output logic                 wait_n,
    output sam_pkg::ram_req_t    cpu_ram_req,
    output logic                 rom_cs,
    output logic [14:0]          rom_addr,
    output logic [7:0]           kb_rows,
    output sam_pkg::page_t       vmpr_page,
    output logic                 beep,
    output logic                 mic
);
    import sam_pkg::*;

    // Decoded strobes
    logic mem_rd;
    logic mem_wr;
    logic io_rd;
    logic io_wr;
    logic active;
    // Set once the current strobe has been served
    logic done;
    // First ROM cycle seen
    logic rom_wait;

    // ASIC registers
    byte_t lmpr;
    byte_t hmpr;
    byte_t vmpr;
    byte_t border;

    logic [1:0] section;
    page_t      page;
    logic       sel_rom;
    byte_t      io_data;

    assign mem_rd = !cpu.mreq_n && !cpu.rd_n;
    assign mem_wr = !cpu.mreq_n && !cpu.wr_n;
    assign io_rd  = !cpu.iorq_n && !cpu.rd_n;
    assign io_wr  = !cpu.iorq_n && !cpu.wr_n;
    assign active = mem_rd | mem_wr | io_rd | io_wr;

    // Stall the CPU until the access completes
    assign wait_n = !(active && !done);

    ////////////////////////////////////////////////////////////
    // Memory paging
    ////////////////////////////////////////////////////////////
    assign section = cpu.addr[15:14];

    always_comb begin
        case (section)
            2'd0:    page = lmpr[4:0];
            2'd1:    page = lmpr[4:0] + 5'd1;
            2'd2:    page = hmpr[4:0];
            default: page = hmpr[4:0] + 5'd1;
        endcase
    end

    // ROM0 over section A unless paged out, ROM1 over section D
    assign sel_rom = ((section == 2'd0) && !lmpr[5]) || ((section == 2'd3) && lmpr[6]);

    assign rom_cs   = (mem_rd | mem_wr) && sel_rom && !done;
    // A15 picks ROM1
    assign rom_addr = {cpu.addr[15], cpu.addr[13:0]};

    always_comb begin
        cpu_ram_req.addr  = {page, cpu.addr[13:0]};
        cpu_ram_req.wdata = cpu.dout;
        cpu_ram_req.rd    = mem_rd && !sel_rom && !done;
        cpu_ram_req.wr    = mem_wr && !sel_rom && !done;
    end

    ////////////////////////////////////////////////////////////
    // I/O side
    ////////////////////////////////////////////////////////////
    // Active low row select from the high address byte
    assign kb_rows   = cpu.addr[15:8];
    assign vmpr_page = vmpr[4:0];
    assign beep      = border[4];
    assign mic       = border[3];

    always_comb begin
        case (cpu.addr[7:0])
            `SAM_PORT_BORDER: io_data = {3'b111, kb_cols};
            `SAM_PORT_LMPR:   io_data = lmpr;
            `SAM_PORT_HMPR:   io_data = hmpr;
            `SAM_PORT_VMPR:   io_data = vmpr;
            // Nothing answers here
            default:          io_data = 8'hff;
        endcase
    end

    // Access sequencing and register writes
    always_ff @(posedge clk24) begin
        if (reset) begin
            done     <= 1'b0;
            rom_wait <= 1'b0;
            lmpr     <= '0;
            hmpr     <= '0;
            vmpr     <= '0;
            border   <= '0;
        end else if (!active) begin
            // Strobes released so arm for the next one
            done     <= 1'b0;
            rom_wait <= 1'b0;
        end else if (!done) begin
            if (io_rd | io_wr) begin
                done <= 1'b1;
                if (io_wr) begin
                    case (cpu.addr[7:0])
                        `SAM_PORT_LMPR:   lmpr   <= cpu.dout;
                        `SAM_PORT_HMPR:   hmpr   <= cpu.dout;
                        `SAM_PORT_VMPR:   vmpr   <= cpu.dout;
                        `SAM_PORT_BORDER: border <= cpu.dout;
                        default:          ;
                    endcase
                end
            end else if (sel_rom) begin
                // ROM data lands one cycle after rom_cs
                rom_wait <= 1'b1;
                if (rom_wait) begin
                    done <= 1'b1;
                end
            end else if (cpu_ram_done) begin
                done <= 1'b1;
            end
        end
    end

    // Read data held for the CPU
    always_ff @(posedge clk24) begin
        if (active && !done) begin
            if (io_rd | io_wr) begin
                if (io_rd) begin
                    cpu_din <= io_data;
                end
            end else if (sel_rom) begin
                cpu_din <= rom_data;
            end else if (cpu_ram_done) begin
                cpu_din <= cpu_ram_rdata;
            end
        end
    end

endmodule

`default_nettype wire

/* sam_consts.svh */
`ifndef SAM_CONSTS_SVH
`define SAM_CONSTS_SVH

////////////////////////////////////////////////////////////
// ASIC I/O port numbers (low address byte)
////////////////////////////////////////////////////////////
`define SAM_PORT_LMPR   8'd250
`define SAM_PORT_HMPR   8'd251
`define SAM_PORT_VMPR   8'd252
// Border on write and keyboard on read
`define SAM_PORT_BORDER 8'd254

////////////////////////////////////////////////////////////
// Frame timing in clk24 cycles
////////////////////////////////////////////////////////////
`define SAM_LINE_CYCLES 96
`define SAM_FETCH_BYTES 32
// Short frame for simulation
`define SAM_FRAME_LINES 8
`define SAM_INT_CYCLES  16

// ROM0 plus ROM1
`define SAM_ROM_WORDS   32768

`endif

/* sam_pkg.sv */
`default_nettype none

package sam_pkg;

    // Bus widths
    typedef logic [15:0] cpu_addr_t;
    typedef logic [18:0] sram_addr_t;
    typedef logic [7:0]  byte_t;
    // One of 32 pages of 16 KB
    typedef logic [4:0]  page_t;

    // Z80 side of the bus with active low strobes
    typedef struct packed {
        cpu_addr_t addr;
        byte_t     dout;
        logic      mreq_n;
        logic      iorq_n;
        logic      rd_n;
        logic      wr_n;
    } cpu_bus_t;

    // Decoder request into the SRAM arbiter
    typedef struct packed {
        sram_addr_t addr;
        byte_t      wdata;
        logic       rd;
        logic       wr;
    } ram_req_t;

    // Make or break for one matrix position
    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
        logic       make;
    } key_event_t;

    // Arbiter slots
    typedef enum logic [1:0] {
        slot_video,
        slot_cpu,
        slot_cpu_done
    } arb_state_t;

endpackage

`default_nettype wire

/* samcoupe_core.sv */
`timescale 1ns/10ps
`default_nettype none

module samcoupe_core (
    input  wire                     clk24,
    input  wire                     reset,
    // Z80 bus
    input  wire sam_pkg::cpu_bus_t  cpu,
    output sam_pkg::byte_t          cpu_din,
    output logic                    wait_n,
    output logic                    int_n,
    // Key events
    input  wire                     key_valid,
    input  wire sam_pkg::key_event_t key,
    // External SRAM
    input  wire sam_pkg::byte_t     sram_din,
    output sam_pkg::sram_addr_t     sram_addr,
    output sam_pkg::byte_t          sram_dout,
    output logic                    sram_we,
    // Raw screen bytes
    output sam_pkg::byte_t          video_byte,
    output logic                    video_valid,
    // Audio
    output logic                    beep,
    output logic                    mic
);
    import sam_pkg::*;

    // Decoder to arbiter
    ram_req_t   cpu_ram_req;
    logic       cpu_ram_done;
    byte_t      cpu_ram_rdata;
    // ROM
    logic       rom_cs;
    logic [14:0] rom_addr;
    byte_t      rom_data;
    // Keyboard
    logic [7:0] kb_rows;
    logic [4:0] kb_cols;
    // Video side
    page_t      vmpr_page;
    logic       whichturn;
    logic       vid_req;
    sram_addr_t vid_addr;
    byte_t      vid_rdata;
    logic       vid_valid;

    sam_bus_decoder i_asic (
        .clk24         (clk24),
        .reset         (reset),
        .cpu           (cpu),
        .kb_cols       (kb_cols),
        .cpu_ram_done  (cpu_ram_done),
        .cpu_ram_rdata (cpu_ram_rdata),
        .rom_data      (rom_data),
        .cpu_din       (cpu_din),
        .wait_n        (wait_n),
        .cpu_ram_req   (cpu_ram_req),
        .rom_cs        (rom_cs),
        .rom_addr      (rom_addr),
        .kb_rows       (kb_rows),
        .vmpr_page     (vmpr_page),
        .beep          (beep),
        .mic           (mic)
    );

    ram_dual_port i_ram_512k (
        .clk24         (clk24),
        .reset         (reset),
        .vid_req       (vid_req),
        .vid_addr      (vid_addr),
        .cpu_ram_req   (cpu_ram_req),
        .sram_din      (sram_din),
        .whichturn     (whichturn),
        .vid_rdata     (vid_rdata),
        .vid_valid     (vid_valid),
        .cpu_ram_done  (cpu_ram_done),
        .cpu_ram_rdata (cpu_ram_rdata),
        .sram_addr     (sram_addr),
        .sram_dout     (sram_dout),
        .sram_we       (sram_we)
    );

    video_fetch i_video (
        .clk24       (clk24),
        .reset       (reset),
        .vmpr_page   (vmpr_page),
        .whichturn   (whichturn),
        .vid_rdata   (vid_rdata),
        .vid_valid   (vid_valid),
        .vid_req     (vid_req),
        .vid_addr    (vid_addr),
        .video_byte  (video_byte),
        .video_valid (video_valid),
        .int_n       (int_n)
    );

    keyboard_matrix i_keyboard (
        .clk24     (clk24),
        .reset     (reset),
        .key_valid (key_valid),
        .key       (key),
        .kb_rows   (kb_rows),
        .kb_cols   (kb_cols)
    );

    rom i_rom_32k (
        .clk24    (clk24),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

endmodule

`default_nettype wire

/* tb_samcoupe.sv */
`timescale 1ns/10ps
`default_nettype none
`include "sam_consts.svh"

module tb_samcoupe;
    import sam_pkg::*;

    localparam int SRAM_BYTES   = 524288;
    localparam int SCREEN_BYTES = `SAM_FETCH_BYTES * `SAM_FRAME_LINES;
    localparam int FRAME_CYCLES = `SAM_LINE_CYCLES * `SAM_FRAME_LINES;
    localparam int BUS_TO       = 16;
    localparam int FRAME_TO     = FRAME_CYCLES * 2;

    // First bytes of each ROM half as stored in rom.hex
    localparam logic [31:0] ROM0_HEAD = 32'hF3C3CB11;
    localparam logic [31:0] ROM1_HEAD = 32'hA55A3C96;

    // Paging used by the SRAM tests
    localparam logic [7:0] LMPR_PAGED  = 8'h24;
    localparam logic [7:0] HMPR_PAGED  = 8'h0A;
    localparam logic [7:0] SCREEN_PAGE = 8'h03;

    logic       clk;
    logic       reset;
    cpu_bus_t   cpu;
    logic       key_valid;
    key_event_t key;
    byte_t      sram_din;
    byte_t      cpu_din;
    logic       wait_n;
    logic       int_n;
    sram_addr_t sram_addr;
    byte_t      sram_dout;
    logic       sram_we;
    byte_t      video_byte;
    logic       video_valid;
    logic       beep;
    logic       mic;

    logic [7:0]  sram_model [0:SRAM_BYTES-1];
    logic [7:0]  screen_ref [SCREEN_BYTES];
    logic [31:0] rand_state = 32'h6047acb5;
    int          cycle_count = 0;
    int          error_count = 0;
    int          timeout_count = 0;

    samcoupe_core i_dut (
        .clk24       (clk),
        .reset       (reset),
        .cpu         (cpu),
        .cpu_din     (cpu_din),
        .wait_n      (wait_n),
        .int_n       (int_n),
        .key_valid   (key_valid),
        .key         (key),
        .sram_din    (sram_din),
        .sram_addr   (sram_addr),
        .sram_dout   (sram_dout),
        .sram_we     (sram_we),
        .video_byte  (video_byte),
        .video_valid (video_valid),
        .beep        (beep),
        .mic         (mic)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    ////////////////////////////////////////////////////////////
    // SRAM model with async read and write on sram_we
    ////////////////////////////////////////////////////////////
    assign sram_din = sram_model[sram_addr];

    initial begin
        for (int i = 0; i < SRAM_BYTES; i++) begin
            sram_model[i] = fill_byte(19'(i));
        end
        forever begin
            @(posedge clk);
            if (sram_we === 1'b1) begin
                sram_model[sram_addr] = sram_dout;
            end
        end
    end

    // Every address bit shows up in the byte
    function automatic logic [7:0] fill_byte(input logic [18:0] a);
        return a[7:0] ^ a[15:8] ^ {5'd0, a[18:16]};
    endfunction

    // LCG with the usual 32-bit constants
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [7:0] head_byte(input logic [31:0] head, input int idx);
        return head[31 - 8 * idx -: 8];
    endfunction

    function automatic logic [15:0] io_port(input logic [7:0] port);
        return {8'h00, port};
    endfunction

    // A and B page from LMPR and C and D from HMPR with B and D one page up
    function automatic logic [18:0] phys_addr(input logic [7:0] lmpr, input logic [7:0] hmpr,
                                              input logic [15:0] addr);
        logic [4:0] page;
        page = (addr[15] ? hmpr[4:0] : lmpr[4:0]) + 5'(addr[14]);
        return {page, addr[13:0]};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        timeout_count++;
        $display("Timeout at %0t while waiting for %s", $time, what);
    endtask

    ////////////////////////////////////////////////////////////
    // CPU bus driver
    ////////////////////////////////////////////////////////////
    task automatic bus_cycle(input logic is_io, input logic is_wr, input logic [15:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata);
        int n;
        @(posedge clk);
        cpu.addr   <= addr;
        cpu.dout   <= wdata;
        cpu.mreq_n <= is_io;
        cpu.iorq_n <= !is_io;
        cpu.rd_n   <= is_wr;
        cpu.wr_n   <= !is_wr;
        n = 0;
        @(negedge clk);
        while (wait_n !== 1'b1 && n < BUS_TO) begin
            @(negedge clk);
            n++;
        end
        if (wait_n !== 1'b1) begin
            note_timeout($sformatf("wait_n on bus access to %h", addr));
        end
        rdata = cpu_din;
        @(posedge clk);
        cpu.mreq_n <= 1'b1;
        cpu.iorq_n <= 1'b1;
        cpu.rd_n   <= 1'b1;
        cpu.wr_n   <= 1'b1;
        // Idle cycle between accesses
        @(posedge clk);
    endtask

    task automatic bus_write(input logic is_io, input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        bus_cycle(is_io, 1'b1, addr, data, unused);
    endtask

    task automatic bus_read(input logic is_io, input logic [15:0] addr, output logic [7:0] data);
        bus_cycle(is_io, 1'b0, addr, 8'h00, data);
    endtask

    task automatic send_key(input logic [2:0] row, input logic [2:0] col, input logic make);
        @(posedge clk);
        key.row   <= row;
        key.col   <= col;
        key.make  <= make;
        key_valid <= 1'b1;
        @(posedge clk);
        key_valid <= 1'b0;
    endtask

    // Returns on the first low sample of a fresh int_n pulse
    task automatic wait_int_fall(output int stamp);
        int n;
        n = 0;
        @(negedge clk);
        while (int_n !== 1'b1 && n < FRAME_TO) begin
            @(negedge clk);
            n++;
        end
        if (int_n !== 1'b1) begin
            note_timeout("int_n to go high");
        end
        n = 0;
        while (int_n !== 1'b0 && n < FRAME_TO) begin
            @(negedge clk);
            n++;
        end
        if (int_n !== 1'b0) begin
            note_timeout("int_n to go low");
        end
        stamp = cycle_count;
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_rom_overlay;
        logic [7:0] d;
        for (int i = 0; i < 4; i++) begin
            bus_read(1'b0, 16'(i), d);
            check_value($sformatf("ROM0 byte %0d", i), 32'(d), 32'(head_byte(ROM0_HEAD, i)));
        end
        // ROM0 paged out by LMPR bit 5
        bus_write(1'b1, io_port(`SAM_PORT_LMPR), 8'h20);
        for (int i = 0; i < 4; i++) begin
            bus_read(1'b0, 16'(i), d);
            check_value($sformatf("SRAM byte %0d", i), 32'(d), 32'(fill_byte(19'(i))));
        end
    endtask

    task automatic test_paging;
        logic [15:0] addrs [8];
        logic [7:0]  vals [8];
        logic [7:0]  d;
        logic [18:0] phys;
        logic [31:0] r;
        bus_write(1'b1, io_port(`SAM_PORT_LMPR), LMPR_PAGED);
        bus_write(1'b1, io_port(`SAM_PORT_HMPR), HMPR_PAGED);
        bus_read(1'b1, io_port(`SAM_PORT_LMPR), d);
        check_value("LMPR readback", 32'(d), 32'(LMPR_PAGED));
        bus_read(1'b1, io_port(`SAM_PORT_HMPR), d);
        check_value("HMPR readback", 32'(d), 32'(HMPR_PAGED));
        // Two writes per section with the low nibble keeping offsets apart
        for (int k = 0; k < 8; k++) begin
            r = next_rand();
            addrs[k] = {2'(k / 2), r[23:14], 4'(k)};
            vals[k] = r[31:24];
            bus_write(1'b0, addrs[k], vals[k]);
            phys = phys_addr(LMPR_PAGED, HMPR_PAGED, addrs[k]);
            check_value($sformatf("SRAM at %h for cpu %h", phys, addrs[k]),
                        32'(sram_model[phys]), 32'(vals[k]));
        end
        for (int k = 0; k < 8; k++) begin
            bus_read(1'b0, addrs[k], d);
            check_value($sformatf("readback %h", addrs[k]), 32'(d), 32'(vals[k]));
        end
    endtask

    task automatic test_rom1;
        logic [7:0] d;
        bus_write(1'b1, io_port(`SAM_PORT_LMPR), 8'h60);
        for (int i = 0; i < 4; i++) begin
            bus_read(1'b0, 16'hC000 + 16'(i), d);
            check_value($sformatf("ROM1 byte %0d", i), 32'(d), 32'(head_byte(ROM1_HEAD, i)));
        end
    endtask

    task automatic test_keyboard;
        logic [7:0] highs [6];
        logic [7:0] exps [6];
        logic [7:0] d;
        highs = '{8'hFF, 8'hFB, 8'hDF, 8'hDB, 8'h00, 8'h7F};
        // Row 2 clears column bit 1 and row 5 clears column bit 3
        exps  = '{8'hFF, 8'hFD, 8'hF7, 8'hF5, 8'hF5, 8'hFF};
        send_key(3'd2, 3'd1, 1'b1);
        send_key(3'd5, 3'd3, 1'b1);
        for (int i = 0; i < 6; i++) begin
            bus_read(1'b1, {highs[i], `SAM_PORT_BORDER}, d);
            check_value($sformatf("keys with rows %h", highs[i]), 32'(d), 32'(exps[i]));
        end
        send_key(3'd2, 3'd1, 1'b0);
        send_key(3'd5, 3'd3, 1'b0);
        bus_read(1'b1, {8'h00, `SAM_PORT_BORDER}, d);
        check_value("keys released", 32'(d), 32'hFF);
    endtask

    task automatic test_border;
        logic [7:0] vals [4];
        logic [7:0] d;
        vals = '{8'h18, 8'h10, 8'h08, 8'h00};
        for (int i = 0; i < 4; i++) begin
            bus_write(1'b1, io_port(`SAM_PORT_BORDER), vals[i]);
            @(negedge clk);
            check_value($sformatf("beep after %h", vals[i]), 32'(beep), 32'(vals[i][4]));
            check_value($sformatf("mic after %h", vals[i]), 32'(mic), 32'(vals[i][3]));
        end
        bus_read(1'b1, io_port(8'h10), d);
        check_value("unused port 10", 32'(d), 32'hFF);
        bus_read(1'b1, io_port(8'hF0), d);
        check_value("unused port F0", 32'(d), 32'hFF);
    endtask

    // Screen bytes arrive in line then column order
    task automatic collect_frame;
        int n;
        for (int k = 0; k < SCREEN_BYTES; k++) begin
            n = 0;
            @(negedge clk);
            while (video_valid !== 1'b1 && n < `SAM_LINE_CYCLES * 2) begin
                @(negedge clk);
                n++;
            end
            if (video_valid !== 1'b1) begin
                note_timeout($sformatf("video byte %0d", k));
                break;
            end
            check_value($sformatf("screen line %0d col %0d", k / `SAM_FETCH_BYTES,
                                  k % `SAM_FETCH_BYTES), 32'(video_byte), 32'(screen_ref[k]));
        end
    endtask

    // CPU traffic in section B next to the video fetch
    task automatic run_bus_traffic;
        logic [15:0] a;
        logic [7:0]  v;
        logic [7:0]  d;
        logic [31:0] r;
        for (int k = 0; k < 6; k++) begin
            r = next_rand();
            a = {2'b01, r[23:14], 4'(k)};
            v = r[31:24];
            bus_write(1'b0, a, v);
            bus_read(1'b0, a, d);
            check_value($sformatf("traffic readback %h", a), 32'(d), 32'(v));
        end
    endtask

    task automatic test_video;
        logic [31:0] r;
        int t0;
        int t1;
        int width;
        // Screen page mapped at section C for the CPU to fill
        bus_write(1'b1, io_port(`SAM_PORT_LMPR), LMPR_PAGED);
        bus_write(1'b1, io_port(`SAM_PORT_HMPR), SCREEN_PAGE);
        for (int i = 0; i < SCREEN_BYTES; i++) begin
            r = next_rand();
            screen_ref[i] = r[31:24];
            bus_write(1'b0, 16'h8000 + 16'(i), screen_ref[i]);
        end
        bus_write(1'b1, io_port(`SAM_PORT_VMPR), SCREEN_PAGE);
        wait_int_fall(t0);
        fork
            collect_frame();
            run_bus_traffic();
        join
        wait_int_fall(t1);
        check_value("frame period", 32'(t1 - t0), 32'(FRAME_CYCLES));
        width = 1;
        @(negedge clk);
        while (int_n === 1'b0 && width < FRAME_TO) begin
            width++;
            @(negedge clk);
        end
        check_value("int_n low width", 32'(width), 32'(`SAM_INT_CYCLES));
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        reset      <= 1'b1;
        cpu.addr   <= 16'h0000;
        cpu.dout   <= 8'h00;
        cpu.mreq_n <= 1'b1;
        cpu.iorq_n <= 1'b1;
        cpu.rd_n   <= 1'b1;
        cpu.wr_n   <= 1'b1;
        key_valid  <= 1'b0;
        key        <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        test_rom_overlay();
        test_paging();
        test_rom1();
        test_keyboard();
        test_border();
        test_video();

        $display("Summary: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* video_fetch.sv */
`timescale 1ns/10ps
`default_nettype none
`include "sam_consts.svh"

module video_fetch (
    input  wire                  clk24,
    input  wire                  reset,
    input  wire sam_pkg::page_t  vmpr_page,
    input  wire                  whichturn,
    input  wire sam_pkg::byte_t  vid_rdata,
    input  wire                  vid_valid,
    output logic                 vid_req,
    output sam_pkg::sram_addr_t  vid_addr,
    output sam_pkg::byte_t       video_byte,
    output logic                 video_valid,
    output logic                 int_n
);
    import sam_pkg::*;

    localparam int COL_W  = $clog2(`SAM_LINE_CYCLES);
    localparam int LINE_W = $clog2(`SAM_FRAME_LINES);

    logic [COL_W-1:0]  col_cnt;
    logic [COL_W-1:0]  col_next;
    logic [LINE_W-1:0] line_cnt;
    logic [LINE_W-1:0] line_next;
    logic              fetch_window;

    ////////////////////////////////////////////////////////////
    // Beam counters
    ////////////////////////////////////////////////////////////
    always_comb begin
        col_next  = col_cnt + 1'b1;
        line_next = line_cnt;
        if (col_cnt == COL_W'(`SAM_LINE_CYCLES - 1)) begin
            col_next = '0;
            if (line_cnt == LINE_W'(`SAM_FRAME_LINES - 1)) begin
                line_next = '0;
            end else begin
                line_next = line_cnt + 1'b1;
            end
        end
    end

    // Reset parks at frame end so line 0 starts right after
    always_ff @(posedge clk24) begin
        if (reset) begin
            col_cnt  <= COL_W'(`SAM_LINE_CYCLES - 1);
            line_cnt <= LINE_W'(`SAM_FRAME_LINES - 1);
            int_n    <= 1'b1;
        end else begin
            col_cnt  <= col_next;
            line_cnt <= line_next;
            // Low through the first cycles of line 0
            int_n    <= !((line_next == '0) && (col_next < COL_W'(`SAM_INT_CYCLES)));
        end
    end

    // One byte per slot pair in the fetch window
    assign fetch_window = (col_cnt < COL_W'(`SAM_FETCH_BYTES * 2));
    assign vid_req      = whichturn && fetch_window;

    // Page base plus line stride plus byte index
    assign vid_addr = {vmpr_page, 14'd0}
                    + sram_addr_t'(line_cnt) * sram_addr_t'(`SAM_FETCH_BYTES)
                    + sram_addr_t'(col_cnt >> 1);

    // Returns arrive in request order
    always_ff @(posedge clk24) begin
        if (reset) begin
            video_valid <= 1'b0;
        end else begin
            video_valid <= vid_valid;
        end
    end

    always_ff @(posedge clk24) begin
        if (vid_valid) begin
            video_byte <= vid_rdata;
        end
    end

endmodule

`default_nettype wire
